/* files.f */
+incdir+verilog
verilog/pifo_pkg.sv
verilog/node_ram.sv
verilog/node_free_list.sv
verilog/pifo_reg.sv
verilog/sorted_list.sv
verilog/pifo_steer.sv
verilog/pifo_top.sv
sim/pifo_chk.sv
sim/pifo_monitor.sv
sim/pifo_tb.sv

/* sim/pifo_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_consts.svh"

module pifo_chk
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire valid_out,
	input wire full,
	input wire count_t num_entries
);

	int assert_fails;

	initial
		assert_fails = 0;

	count_in_range: assert property (@(posedge clk) disable iff (rst)
		num_entries <= `PIFO_CAPACITY)
	else
	begin
		assert_fails++;
		$error("num_entries exceeds the queue capacity");
	end

	// An empty queue shows no head entry
	empty_not_valid: assert property (@(posedge clk) disable iff (rst)
		(num_entries == '0) |-> !valid_out)
	else
	begin
		assert_fails++;
		$error("valid_out is high while num_entries is zero");
	end

	not_full_after_rst: assert property (@(posedge clk) rst |=> !full)
	else
	begin
		assert_fails++;
		$error("full is high in the cycle after reset");
	end

endmodule

bind pifo_top pifo_chk i_pifo_chk (
	.clk         (clk),
	.rst         (rst),
	.valid_out   (valid_out),
	.full        (full),
	.num_entries (num_entries)
);

`default_nettype wire

/* sim/pifo_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_monitor
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire remove,
	input wire busy,
	input wire full,
	input wire valid_out,
	input wire rank_t rank_out,
	input wire meta_t meta_out,
	input wire count_t num_entries,
	input wire check_flags,
	input wire rank_t exp_rank,
	input wire meta_t exp_meta,
	input wire count_t exp_count,
	input wire exp_busy,
	input wire exp_full,
	input wire exp_valid,
	output int err_count
);

	logic rmv_accept;

	// Same acceptance rule as the DUT applies to a remove
	assign rmv_accept = remove && valid_out && !busy;

	initial
		err_count = 0;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			err_count++;
		end
	endtask

	// Sampled at the rising edge, before the DUT registers update
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (rmv_accept)
			begin
				compare_value("rank_out", rank_out, exp_rank);
				compare_value("meta_out", meta_out, exp_meta);
				compare_value("num_entries", num_entries, exp_count);
			end
			if (check_flags)
			begin
				if (exp_busy)
					compare_value("busy", busy, exp_busy);
				compare_value("full", full, exp_full);
				compare_value("valid_out", valid_out, exp_valid);
				compare_value("num_entries", num_entries, exp_count);
			end
		end
	end

endmodule

`default_nettype wire

/* sim/pifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_consts.svh"

module pifo_tb
	import pifo_pkg::*;
();

	localparam int MODEL_SIZE = 64;
	localparam int SEED = 32'hd0e2;
	localparam int MIX_OPS = 80;
	localparam int TOTAL_OPS = 2 * 3 + 2 * 20 + 2 * `PIFO_CAPACITY + MIX_OPS;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * (`PIFO_CAPACITY + 8) + 64;

	logic clk;
	logic rst;
	logic insert;
	logic remove;
	rank_t rank_in;
	meta_t meta_in;
	rank_t rank_out;
	meta_t meta_out;
	logic valid_out;
	count_t num_entries;
	logic busy;
	logic full;

	logic check_flags;
	rank_t exp_rank;
	meta_t exp_meta;
	count_t exp_count;
	logic exp_busy;
	logic exp_full;
	logic exp_valid;
	int err_count;

	// Entries the queue should hold, in no particular order
	rank_t model_rank [0:MODEL_SIZE-1];
	meta_t model_meta [0:MODEL_SIZE-1];
	int model_cnt;
	bit rank_used [0:(1 << `PIFO_RANK_W)-1];
	int tests_run;
	int tests_bad;
	int errs_before;
	int total_errs;

	pifo_top i_pifo_top (
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.rank_in     (rank_in),
		.meta_in     (meta_in),
		.rank_out    (rank_out),
		.meta_out    (meta_out),
		.valid_out   (valid_out),
		.num_entries (num_entries),
		.busy        (busy),
		.full        (full)
	);

	pifo_monitor i_monitor (
		.clk         (clk),
		.rst         (rst),
		.remove      (remove),
		.busy        (busy),
		.full        (full),
		.valid_out   (valid_out),
		.rank_out    (rank_out),
		.meta_out    (meta_out),
		.num_entries (num_entries),
		.check_flags (check_flags),
		.exp_rank    (exp_rank),
		.exp_meta    (exp_meta),
		.exp_count   (exp_count),
		.exp_busy    (exp_busy),
		.exp_full    (exp_full),
		.exp_valid   (exp_valid),
		.err_count   (err_count)
	);

	initial
		clk = 1'b0;

	always #50 clk = ~clk;

	// Reference model returning the index of the held entry with the smallest rank
	function automatic int min_index();
		int best;
		best = 0;
		for (int i = 1; i < model_cnt; i++)
			if (model_rank[i] < model_rank[best])
				best = i;
		return best;
	endfunction

	function automatic rank_t fresh_rank();
		rank_t r;
		r = rank_t'($urandom);
		while (rank_used[r])
			r = rank_t'($urandom);
		rank_used[r] = 1'b1;
		return r;
	endfunction

	task automatic push_entry(input rank_t r, input meta_t m);
		while (busy || full)
			@(negedge clk);
		insert = 1'b1;
		rank_in = r;
		meta_in = m;
		@(negedge clk);
		insert = 1'b0;
		model_rank[model_cnt] = r;
		model_meta[model_cnt] = m;
		model_cnt++;
	endtask

	task automatic pop_entry();
		int idx;
		while (busy || !valid_out)
			@(negedge clk);
		idx = min_index();
		exp_rank = model_rank[idx];
		exp_meta = model_meta[idx];
		exp_count = count_t'(model_cnt);
		remove = 1'b1;
		@(negedge clk);
		remove = 1'b0;
		model_rank[idx] = model_rank[model_cnt-1];
		model_meta[idx] = model_meta[model_cnt-1];
		model_cnt--;
	endtask

	task automatic expect_state(input logic b, input logic f, input logic v);
		if (!b)
			while (busy)
				@(negedge clk);
		exp_busy = b;
		exp_full = f;
		exp_valid = v;
		exp_count = count_t'(model_cnt);
		check_flags = 1'b1;
		@(negedge clk);
		check_flags = 1'b0;
	endtask

	task automatic drain_all();
		while (model_cnt > 0)
			pop_entry();
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		tests_run++;
		if (err_count == errs_at_start)
			$display("%s: ok", name);
		else
		begin
			tests_bad++;
			$display("%s: %0d mismatches", name, err_count - errs_at_start);
		end
	endtask

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("The run timed out after %0d cycles waiting on the DUT", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in = '0;
		check_flags = 1'b0;
		exp_rank = '0;
		exp_meta = '0;
		exp_count = '0;
		exp_busy = 1'b0;
		exp_full = 1'b0;
		exp_valid = 1'b0;
		model_cnt = 0;
		tests_run = 0;
		tests_bad = 0;
		void'($urandom(SEED));
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Free list fills itself first
		errs_before = err_count;
		expect_state(1'b1, 1'b0, 1'b0);
		expect_state(1'b0, 1'b0, 1'b0);
		report_test("Test 1 reset state", errs_before);

		errs_before = err_count;
		for (int i = 0; i < 3; i++)
			push_entry(fresh_rank(), meta_t'($urandom));
		drain_all();
		expect_state(1'b0, 1'b0, 1'b0);
		report_test("Test 2 three entries", errs_before);

		// Enough entries to spill into the list and refill from it
		errs_before = err_count;
		for (int i = 0; i < 20; i++)
			push_entry(fresh_rank(), meta_t'($urandom));
		drain_all();
		expect_state(1'b0, 1'b0, 1'b0);
		report_test("Test 3 twenty random entries", errs_before);

		errs_before = err_count;
		for (int i = 0; i < `PIFO_CAPACITY; i++)
			push_entry(fresh_rank(), meta_t'($urandom));
		expect_state(1'b0, 1'b1, 1'b1);
		drain_all();
		expect_state(1'b0, 1'b0, 1'b0);
		report_test("Test 4 fill to capacity", errs_before);

		errs_before = err_count;
		for (int i = 0; i < MIX_OPS; i++)
		begin
			if (model_cnt == 0 || (model_cnt < `PIFO_CAPACITY && $urandom % 2 == 0))
				push_entry(fresh_rank(), meta_t'($urandom));
			else
				pop_entry();
		end
		expect_state(1'b0, model_cnt == `PIFO_CAPACITY, model_cnt != 0);
		report_test("Test 5 random mix", errs_before);

		total_errs = err_count + i_pifo_top.i_pifo_chk.assert_fails;
		$display("Tests run %0d, tests with mismatches %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_bad, err_count, i_pifo_top.i_pifo_chk.assert_fails);
		if (total_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/node_free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_consts.svh"

module node_free_list
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire alloc,
	output ptr_t free_ptr,
	input wire release_req,
	input wire ptr_t release_ptr,
	output logic free_empty,
	output logic init_busy
);

	ptr_t fifo_mem [0:(1 << `PIFO_L2_NODES)-1];
	ptr_t rd_ptr;
	ptr_t wr_ptr;
	ptr_t init_idx;
	logic push_en;
	ptr_t push_val;

	// During init the FIFO fills itself with indices 0 up to NULL-1
	assign push_en = init_busy | release_req;
	assign push_val = init_busy ? init_idx : release_ptr;

	always_ff @(posedge clk)
	begin
		if (push_en)
			fifo_mem[wr_ptr] <= push_val;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			init_idx <= '0;
			init_busy <= 1'b1;
		end
		else
		begin
			if (push_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (alloc && !free_empty)
				rd_ptr <= rd_ptr + 1'b1;
			if (init_busy)
			begin
				init_idx <= init_idx + 1'b1;
				if (init_idx == `PIFO_NULL_PTR - 1'b1)
					init_busy <= 1'b0;
			end
		end
	end

	// Never more than 31 indices inside, so equal pointers mean empty
	assign free_empty = (rd_ptr == wr_ptr);
	assign free_ptr = fifo_mem[rd_ptr];

endmodule

`default_nettype wire

/* verilog/node_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_consts.svh"

module node_ram
#(
	parameter int W = 20
)
(
	input wire clk,
	input wire wr,
	input wire [`PIFO_L2_NODES-1:0] waddr,
	input wire [W-1:0] din,
	input wire [`PIFO_L2_NODES-1:0] raddr,
	output logic [W-1:0] dout
);

	logic [W-1:0] mem [0:(1 << `PIFO_L2_NODES)-1];

	// Read port is always enabled, old data on a same-address write
	always_ff @(posedge clk)
	begin
		if (wr)
			mem[waddr] <= din;
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

/* verilog/pifo_consts.svh */
`ifndef PIFO_CONSTS_SVH
`define PIFO_CONSTS_SVH

// Entry payload widths
`define PIFO_RANK_W 10
`define PIFO_META_W 10

// Node memory holds 2**PIFO_L2_NODES nodes
`define PIFO_L2_NODES 5

// Slots in the sorted register front
`define PIFO_REG_SLOTS 4

// End-of-list marker, so the last node index is never handed out
`define PIFO_NULL_PTR {`PIFO_L2_NODES{1'b1}}

// Front slots plus the usable list nodes
`define PIFO_CAPACITY (`PIFO_REG_SLOTS + (1 << `PIFO_L2_NODES) - 1)

`endif

/* verilog/pifo_pkg.sv */
`default_nettype none

`include "pifo_consts.svh"

package pifo_pkg;

	typedef logic [`PIFO_RANK_W-1:0] rank_t;
	typedef logic [`PIFO_META_W-1:0] meta_t;
	typedef logic [`PIFO_L2_NODES-1:0] ptr_t;

	// Counts must reach their maximum, hence the +1
	typedef logic [$clog2(`PIFO_CAPACITY + 1)-1:0] count_t;
	typedef logic [$clog2(`PIFO_REG_SLOTS + 1)-1:0] slot_cnt_t;

	typedef enum logic [2:0] {
		LS_IDLE,
		LS_RD_HEAD,
		LS_WALK,
		LS_LINK,
		LS_POP_RD,
		LS_POP_DONE
	} list_state_t;

endpackage

`default_nettype wire

/* verilog/pifo_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_consts.svh"

module pifo_reg
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire insert,
	input wire rank_t rank_in,
	input wire meta_t meta_in,
	input wire pop,
	output rank_t min_rank,
	output meta_t min_meta,
	output logic min_valid,
	output rank_t max_rank,
	output logic room,
	output logic evict_valid,
	output rank_t evict_rank,
	output meta_t evict_meta
);

	rank_t rank_q [0:`PIFO_REG_SLOTS-1];
	meta_t meta_q [0:`PIFO_REG_SLOTS-1];
	slot_cnt_t cnt;

	logic [`PIFO_REG_SLOTS-1:0] keep;
	rank_t ins_rank [0:`PIFO_REG_SLOTS-1];
	meta_t ins_meta [0:`PIFO_REG_SLOTS-1];
	rank_t spill_rank;
	meta_t spill_meta;

	// Slots at or below the new rank stay, the rest shift up by one
	always_comb
	begin
		for (int i = 0; i < `PIFO_REG_SLOTS; i++)
			keep[i] = (i < cnt) && (rank_q[i] <= rank_in);
		ins_rank[0] = keep[0] ? rank_q[0] : rank_in;
		ins_meta[0] = keep[0] ? meta_q[0] : meta_in;
		for (int i = 1; i < `PIFO_REG_SLOTS; i++)
		begin
			ins_rank[i] = keep[i] ? rank_q[i] : (keep[i-1] ? rank_in : rank_q[i-1]);
			ins_meta[i] = keep[i] ? meta_q[i] : (keep[i-1] ? meta_in : meta_q[i-1]);
		end
		// Entry pushed past the last slot
		spill_rank = keep[`PIFO_REG_SLOTS-1] ? rank_in : rank_q[`PIFO_REG_SLOTS-1];
		spill_meta = keep[`PIFO_REG_SLOTS-1] ? meta_in : meta_q[`PIFO_REG_SLOTS-1];
	end

	always_ff @(posedge clk)
	begin
		if (insert)
		begin
			for (int i = 0; i < `PIFO_REG_SLOTS; i++)
			begin
				rank_q[i] <= ins_rank[i];
				meta_q[i] <= ins_meta[i];
			end
			evict_rank <= spill_rank;
			evict_meta <= spill_meta;
		end
		else if (pop)
		begin
			for (int i = 0; i < `PIFO_REG_SLOTS - 1; i++)
			begin
				rank_q[i] <= rank_q[i+1];
				meta_q[i] <= meta_q[i+1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt <= '0;
			evict_valid <= 1'b0;
		end
		else
		begin
			evict_valid <= insert && !room;
			if (insert && room)
				cnt <= cnt + 1'b1;
			else if (pop && min_valid)
				cnt <= cnt - 1'b1;
		end
	end

	// Largest held rank sits in the last occupied slot
	always_comb
	begin
		max_rank = rank_q[0];
		for (int i = 1; i < `PIFO_REG_SLOTS; i++)
			if (cnt > i)
				max_rank = rank_q[i];
	end

	assign min_rank = rank_q[0];
	assign min_meta = meta_q[0];
	assign min_valid = (cnt != '0);
	assign room = (cnt < `PIFO_REG_SLOTS);

endmodule

`default_nettype wire

/* verilog/pifo_steer.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_steer
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	input wire rank_t rank_in,
	input wire meta_t meta_in,
	output logic reg_insert,
	output rank_t reg_rank,
	output meta_t reg_meta,
	output logic reg_pop,
	input wire min_valid,
	input wire rank_t max_rank,
	input wire room,
	input wire evict_valid,
	input wire rank_t evict_rank,
	input wire meta_t evict_meta,
	output logic list_push,
	output rank_t list_rank,
	output meta_t list_meta,
	output logic list_pop,
	input wire list_busy,
	input wire list_empty,
	input wire list_full,
	input wire pop_valid,
	input wire rank_t pop_rank,
	input wire meta_t pop_meta,
	output logic busy,
	output logic full,
	output count_t num_entries
);

	logic to_front;
	logic accept_ins;
	logic accept_rmv;
	logic refill_due;

	// Front takes ranks below its max, or everything when both parts are empty
	assign to_front = (min_valid && rank_in < max_rank) || (!min_valid && list_empty);

	assign accept_ins = insert && !busy && !full;
	assign accept_rmv = remove && min_valid && !busy;
	assign refill_due = room && !list_empty;

	// Refilled entries come from the list head, new ones from the port
	assign reg_insert = (accept_ins && to_front) || pop_valid;
	assign reg_rank = pop_valid ? pop_rank : rank_in;
	assign reg_meta = pop_valid ? pop_meta : meta_in;
	assign reg_pop = accept_rmv;

	// An eviction always wins the list's push port
	assign list_push = evict_valid || (accept_ins && !to_front);
	assign list_rank = evict_valid ? evict_rank : rank_in;
	assign list_meta = evict_valid ? evict_meta : meta_in;
	assign list_pop = refill_due && !list_busy;

	assign busy = list_busy || evict_valid || refill_due;
	assign full = list_full;

	always_ff @(posedge clk)
	begin
		if (rst)
			num_entries <= '0;
		else if (accept_ins)
			num_entries <= num_entries + 1'b1;
		else if (accept_rmv)
			num_entries <= num_entries - 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/pifo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_top
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	input wire rank_t rank_in,
	input wire meta_t meta_in,
	output rank_t rank_out,
	output meta_t meta_out,
	output logic valid_out,
	output count_t num_entries,
	output logic busy,
	output logic full
);

	logic reg_insert;
	rank_t reg_rank;
	meta_t reg_meta;
	logic reg_pop;
	rank_t max_rank;
	logic room;
	logic evict_valid;
	rank_t evict_rank;
	meta_t evict_meta;

	logic list_push;
	rank_t list_rank;
	meta_t list_meta;
	logic list_pop;
	logic pop_valid;
	rank_t pop_rank;
	meta_t pop_meta;
	logic list_busy;
	logic list_empty;
	logic list_full;

	// Front minimum is the global minimum
	pifo_reg i_pifo_reg (
		.clk         (clk),
		.rst         (rst),
		.insert      (reg_insert),
		.rank_in     (reg_rank),
		.meta_in     (reg_meta),
		.pop         (reg_pop),
		.min_rank    (rank_out),
		.min_meta    (meta_out),
		.min_valid   (valid_out),
		.max_rank    (max_rank),
		.room        (room),
		.evict_valid (evict_valid),
		.evict_rank  (evict_rank),
		.evict_meta  (evict_meta)
	);

	sorted_list i_sorted_list (
		.clk        (clk),
		.rst        (rst),
		.push       (list_push),
		.push_rank  (list_rank),
		.push_meta  (list_meta),
		.pop        (list_pop),
		.pop_valid  (pop_valid),
		.pop_rank   (pop_rank),
		.pop_meta   (pop_meta),
		.list_busy  (list_busy),
		.list_empty (list_empty),
		.list_full  (list_full)
	);

	pifo_steer i_pifo_steer (
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.rank_in     (rank_in),
		.meta_in     (meta_in),
		.reg_insert  (reg_insert),
		.reg_rank    (reg_rank),
		.reg_meta    (reg_meta),
		.reg_pop     (reg_pop),
		.min_valid   (valid_out),
		.max_rank    (max_rank),
		.room        (room),
		.evict_valid (evict_valid),
		.evict_rank  (evict_rank),
		.evict_meta  (evict_meta),
		.list_push   (list_push),
		.list_rank   (list_rank),
		.list_meta   (list_meta),
		.list_pop    (list_pop),
		.list_busy   (list_busy),
		.list_empty  (list_empty),
		.list_full   (list_full),
		.pop_valid   (pop_valid),
		.pop_rank    (pop_rank),
		.pop_meta    (pop_meta),
		.busy        (busy),
		.full        (full),
		.num_entries (num_entries)
	);

endmodule

`default_nettype wire

/* verilog/sorted_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pifo_consts.svh"

module sorted_list
	import pifo_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire push,
	input wire rank_t push_rank,
	input wire meta_t push_meta,
	input wire pop,
	output logic pop_valid,
	output rank_t pop_rank,
	output meta_t pop_meta,
	output logic list_busy,
	output logic list_empty,
	output logic list_full
);

	list_state_t state;
	ptr_t head;
	ptr_t cur;
	ptr_t prev;
	ptr_t new_ptr;
	rank_t new_rank;
	meta_t new_meta;
	logic link_second;

	logic alloc;
	logic release_req;
	ptr_t free_ptr;
	logic free_empty;
	logic init_busy;

	ptr_t raddr;
	logic ent_wr;
	logic [`PIFO_RANK_W+`PIFO_META_W-1:0] ent_dout;
	logic nxt_wr;
	ptr_t nxt_waddr;
	ptr_t nxt_din;
	ptr_t nxt_dout;
	rank_t node_rank;

	node_free_list i_free_list (
		.clk         (clk),
		.rst         (rst),
		.alloc       (alloc),
		.free_ptr    (free_ptr),
		.release_req (release_req),
		.release_ptr (head),
		.free_empty  (free_empty),
		.init_busy   (init_busy)
	);

	// Rank in the upper half, metadata in the lower half
	node_ram #(.W(`PIFO_RANK_W + `PIFO_META_W)) i_entry_ram (
		.clk   (clk),
		.wr    (ent_wr),
		.waddr (new_ptr),
		.din   ({new_rank, new_meta}),
		.raddr (raddr),
		.dout  (ent_dout)
	);

	node_ram #(.W(`PIFO_L2_NODES)) i_next_ram (
		.clk   (clk),
		.wr    (nxt_wr),
		.waddr (nxt_waddr),
		.din   (nxt_din),
		.raddr (raddr),
		.dout  (nxt_dout)
	);

	assign node_rank = ent_dout[`PIFO_RANK_W+`PIFO_META_W-1:`PIFO_META_W];

	// While walking, follow the next pointer of the node just read
	assign raddr = (state == LS_WALK) ? nxt_dout : head;

	// First link cycle writes the new node, the second relinks its left neighbour
	assign ent_wr = (state == LS_LINK) && !link_second;
	assign nxt_wr = (state == LS_LINK) && (!link_second || prev != `PIFO_NULL_PTR);
	assign nxt_waddr = link_second ? prev : new_ptr;
	assign nxt_din = link_second ? new_ptr : cur;

	assign alloc = (state == LS_IDLE) && push && !init_busy;
	assign release_req = (state == LS_POP_RD);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= LS_IDLE;
			head <= `PIFO_NULL_PTR;
			link_second <= 1'b0;
		end
		else
		begin
			case (state)
				LS_IDLE:
				begin
					if (alloc)
					begin
						new_ptr <= free_ptr;
						new_rank <= push_rank;
						new_meta <= push_meta;
						prev <= `PIFO_NULL_PTR;
						state <= LS_RD_HEAD;
					end
					else if (pop && !list_empty && !init_busy)
						state <= LS_POP_RD;
				end
				LS_RD_HEAD:
				begin
					cur <= head;
					state <= list_empty ? LS_LINK : LS_WALK;
				end
				LS_WALK:
				begin
					// Equal ranks are passed so arrival order is kept
					if (node_rank <= new_rank)
					begin
						prev <= cur;
						cur <= nxt_dout;
						if (nxt_dout == `PIFO_NULL_PTR)
							state <= LS_LINK;
					end
					else
						state <= LS_LINK;
				end
				LS_LINK:
				begin
					link_second <= !link_second;
					if (link_second)
					begin
						if (prev == `PIFO_NULL_PTR)
							head <= new_ptr;
						state <= LS_IDLE;
					end
				end
				LS_POP_RD:
				begin
					pop_rank <= node_rank;
					pop_meta <= ent_dout[`PIFO_META_W-1:0];
					head <= nxt_dout;
					state <= LS_POP_DONE;
				end
				default:
					state <= LS_IDLE;
			endcase
		end
	end

	assign pop_valid = (state == LS_POP_DONE);
	assign list_busy = init_busy || (state != LS_IDLE);
	assign list_empty = (head == `PIFO_NULL_PTR);
	assign list_full = free_empty && !init_busy;

endmodule

`default_nettype wire
